//--- Makefile
VERILATOR  ?= verilator
TOP        := tb_dma_mm
FILELIST   := sources.f
OBJ_DIR    := obj_dir
SIM_FLAGS  := --binary --timing --assert -j 0 --Mdir $(OBJ_DIR)
LINT_FLAGS := --lint-only -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

//--- dma_mm_pkg.sv
`default_nettype none

package dma_mm_pkg;

    localparam int MAT_DIM      = 4;
    localparam int VEC_COUNT    = 8;    // A row 0, four B columns, A rows 1 to 3
    localparam int RESULT_COUNT = 16;
    localparam int WORD_BYTES   = 4;

    // wishbone byte offsets, decoded on adr[7:0]
    localparam logic [7:0] REG_CTRL   = 8'h00;
    localparam logic [7:0] REG_BASE_A = 8'h04;
    localparam logic [7:0] REG_BASE_B = 8'h08;

    localparam int CTRL_START_BIT = 0;
    localparam int STAT_DONE_BIT  = 1;
    localparam int STAT_IDLE_BIT  = 2;

    typedef enum logic {
        VEC_A_ROW,
        VEC_B_COL
    } vec_kind_e;

    typedef struct packed {
        vec_kind_e                  kind;
        logic [$clog2(MAT_DIM)-1:0] idx;   // row of A or column of B
    } vec_sel_t;

    // order in which the engine consumes operand vectors
    localparam vec_sel_t VEC_ORDER [VEC_COUNT] = '{
        '{VEC_A_ROW, 2'd0},
        '{VEC_B_COL, 2'd0},
        '{VEC_B_COL, 2'd1},
        '{VEC_B_COL, 2'd2},
        '{VEC_B_COL, 2'd3},
        '{VEC_A_ROW, 2'd1},
        '{VEC_A_ROW, 2'd2},
        '{VEC_A_ROW, 2'd3}
    };

endpackage

`default_nettype wire

//--- dma_mm_regs.sv
`timescale 1ns/1ps
`default_nettype none

module dma_mm_regs #(
    parameter int ADDR_W = 23,
    parameter int DATA_W = 32
) (
    input  logic              wb_clk_i,
    input  logic              wb_rst_i,
    input  logic              wbs_stb_i,
    input  logic              wbs_cyc_i,
    input  logic              wbs_we_i,
    input  logic [3:0]        wbs_sel_i,
    input  logic [31:0]       wbs_adr_i,
    input  logic [DATA_W-1:0] wbs_dat_i,
    output logic              wbs_ack_o,
    output logic [DATA_W-1:0] wbs_dat_o,
    output logic [ADDR_W-1:0] base_a_o,
    output logic [ADDR_W-1:0] base_b_o,
    output logic              start_o,
    input  logic              run_done_i
);
    import dma_mm_pkg::*;

    logic              base_a_set_q;
    logic              base_b_set_q;
    logic              run_q;
    logic              done_q;
    logic              take;
    logic              wr;
    logic              start_go;
    logic [7:0]        reg_sel;
    logic [DATA_W-1:0] rd_data;

    assign take     = wbs_stb_i && wbs_cyc_i && !wbs_ack_o;   // one cycle gap after each ack
    assign wr       = take && wbs_we_i && (wbs_sel_i == 4'hf);
    assign reg_sel  = wbs_adr_i[7:0];
    assign start_go = wr && (reg_sel == REG_CTRL) && wbs_dat_i[CTRL_START_BIT]
                      && base_a_set_q && base_b_set_q && !run_q;

    always_comb begin
        rd_data = '0;
        case (reg_sel)
            REG_CTRL: begin
                rd_data[STAT_DONE_BIT] = done_q;
                rd_data[STAT_IDLE_BIT] = !run_q;
            end
            REG_BASE_A: rd_data = DATA_W'(base_a_o);
            REG_BASE_B: rd_data = DATA_W'(base_b_o);
            default:    rd_data = '0;     // unmapped reads as zero
        endcase
    end

    always_ff @(posedge wb_clk_i) begin
        if (wb_rst_i) begin
            wbs_ack_o    <= 1'b0;
            wbs_dat_o    <= '0;
            base_a_o     <= '0;
            base_b_o     <= '0;
            base_a_set_q <= 1'b0;
            base_b_set_q <= 1'b0;
            start_o      <= 1'b0;
            run_q        <= 1'b0;
            done_q       <= 1'b0;
        end else begin
            wbs_ack_o <= take;
            wbs_dat_o <= (take && !wbs_we_i) ? rd_data : '0;
            start_o   <= start_go;
            // bases frozen while a run is active
            if (wr && !run_q && reg_sel == REG_BASE_A) begin
                base_a_o     <= wbs_dat_i[ADDR_W-1:0];
                base_a_set_q <= 1'b1;
            end
            if (wr && !run_q && reg_sel == REG_BASE_B) begin
                base_b_o     <= wbs_dat_i[ADDR_W-1:0];
                base_b_set_q <= 1'b1;
            end
            if (start_go) begin
                run_q  <= 1'b1;
                done_q <= 1'b0;
            end else if (run_done_i) begin
                run_q  <= 1'b0;
                done_q <= 1'b1;
            end
        end
    end

    // a start pulse opens a run that was closed the cycle before
    a_start_idle: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
        start_o |-> run_q && $past(!run_q));

endmodule

`default_nettype wire

//--- dma_mm_top.sv
`timescale 1ns/1ps
`default_nettype none

module dma_mm_top #(
    parameter int ADDR_W = 23,
    parameter int DATA_W = 32
) (
    input  logic              wb_clk_i,
    input  logic              wb_rst_i,
    input  logic              wbs_stb_i,
    input  logic              wbs_cyc_i,
    input  logic              wbs_we_i,
    input  logic [3:0]        wbs_sel_i,
    input  logic [31:0]       wbs_adr_i,
    input  logic [31:0]       wbs_dat_i,
    output logic              wbs_ack_o,
    output logic [31:0]       wbs_dat_o,
    output logic [ADDR_W-1:0] sdram_addr_o,
    output logic              sdram_rw_o,
    output logic [DATA_W-1:0] sdram_wdata_o,
    output logic              sdram_in_valid_o,
    output logic              sdram_prefetch_o,
    input  logic              sdram_busy_i,
    input  logic              sdram_out_valid_i,
    input  logic [DATA_W-1:0] sdram_rdata_i,
    output logic              eng_start_o,
    output logic              eng_in_valid_o,
    output logic [DATA_W-1:0] eng_in_data_o,
    input  logic              eng_in_ready_i,
    input  logic              eng_out_valid_i,
    input  logic [DATA_W-1:0] eng_out_data_i,
    output logic              eng_out_ready_o,
    input  logic              eng_done_i
);
    logic [ADDR_W-1:0] base_a;
    logic [ADDR_W-1:0] base_b;
    logic              run_start;
    logic              run_done;

    mem_req_if #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) fetch_if ();
    mem_req_if #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) wback_if ();

    assign eng_start_o = run_start;     // engine starts with the DMA

    dma_mm_regs #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) u_regs (
        .wb_clk_i   (wb_clk_i),
        .wb_rst_i   (wb_rst_i),
        .wbs_stb_i  (wbs_stb_i),
        .wbs_cyc_i  (wbs_cyc_i),
        .wbs_we_i   (wbs_we_i),
        .wbs_sel_i  (wbs_sel_i),
        .wbs_adr_i  (wbs_adr_i),
        .wbs_dat_i  (wbs_dat_i),
        .wbs_ack_o  (wbs_ack_o),
        .wbs_dat_o  (wbs_dat_o),
        .base_a_o   (base_a),
        .base_b_o   (base_b),
        .start_o    (run_start),
        .run_done_i (run_done)
    );

    operand_feeder #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) u_feeder (
        .wb_clk_i       (wb_clk_i),
        .wb_rst_i       (wb_rst_i),
        .start_i        (run_start),
        .base_a_i       (base_a),
        .base_b_i       (base_b),
        .mem            (fetch_if.requester),
        .eng_in_valid_o (eng_in_valid_o),
        .eng_in_data_o  (eng_in_data_o),
        .eng_in_ready_i (eng_in_ready_i)
    );

    result_writeback #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) u_wback (
        .wb_clk_i        (wb_clk_i),
        .wb_rst_i        (wb_rst_i),
        .start_i         (run_start),
        .base_a_i        (base_a),
        .mem             (wback_if.requester),
        .eng_out_valid_i (eng_out_valid_i),
        .eng_out_data_i  (eng_out_data_i),
        .eng_out_ready_o (eng_out_ready_o),
        .eng_done_i      (eng_done_i),
        .run_done_o      (run_done)
    );

    sdram_port_arb #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) u_arb (
        .wb_clk_i          (wb_clk_i),
        .wb_rst_i          (wb_rst_i),
        .fetch             (fetch_if.arbiter),
        .wback             (wback_if.arbiter),
        .sdram_addr_o      (sdram_addr_o),
        .sdram_rw_o        (sdram_rw_o),
        .sdram_wdata_o     (sdram_wdata_o),
        .sdram_in_valid_o  (sdram_in_valid_o),
        .sdram_prefetch_o  (sdram_prefetch_o),
        .sdram_busy_i      (sdram_busy_i),
        .sdram_out_valid_i (sdram_out_valid_i),
        .sdram_rdata_i     (sdram_rdata_i)
    );

endmodule

`default_nettype wire

//--- mem_req_if.sv
`timescale 1ns/1ps
`default_nettype none

interface mem_req_if #(
    parameter int ADDR_W = 23,
    parameter int DATA_W = 32
);
    logic              req;
    logic              rw;           // 1 = write
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
    logic              prefetch;
    logic              accept;       // controller took the request
    logic              rdata_valid;
    logic [DATA_W-1:0] rdata;
    logic              done;         // transaction over, requester may move on

    modport requester (
        output req, rw, addr, wdata, prefetch,
        input  accept, rdata_valid, rdata, done
    );

    modport arbiter (
        input  req, rw, addr, wdata, prefetch,
        output accept, rdata_valid, rdata, done
    );
endinterface

`default_nettype wire

//--- operand_feeder.sv
`timescale 1ns/1ps
`default_nettype none

module operand_feeder #(
    parameter int ADDR_W = 23,
    parameter int DATA_W = 32
) (
    input  logic              wb_clk_i,
    input  logic              wb_rst_i,
    input  logic              start_i,
    input  logic [ADDR_W-1:0] base_a_i,
    input  logic [ADDR_W-1:0] base_b_i,
    mem_req_if.requester      mem,
    output logic              eng_in_valid_o,
    output logic [DATA_W-1:0] eng_in_data_o,
    input  logic              eng_in_ready_i
);
    import dma_mm_pkg::*;

    localparam int VEC_W  = $clog2(VEC_COUNT);
    localparam int WORD_W = $clog2(MAT_DIM);

    logic              active_q;
    logic              full_q;       // four words buffered, streaming to engine
    logic [VEC_W-1:0]  vec_q;
    logic [WORD_W-1:0] word_q;       // next word to fetch
    logic [WORD_W-1:0] out_q;        // next word to stream
    logic [DATA_W-1:0] buf_q [MAT_DIM];
    vec_sel_t          cur;
    int                elem;
    logic              beat;

    assign cur = VEC_ORDER[vec_q];

    // A rows are contiguous, B columns step by a full row
    always_comb begin
        if (cur.kind == VEC_A_ROW)
            elem = int'(cur.idx) * MAT_DIM + int'(word_q);
        else
            elem = int'(word_q) * MAT_DIM + int'(cur.idx);
    end

    assign mem.req      = active_q && !full_q;
    assign mem.rw       = 1'b0;
    assign mem.addr     = ((cur.kind == VEC_A_ROW) ? base_a_i : base_b_i)
                          + ADDR_W'(elem * WORD_BYTES);
    assign mem.wdata    = '0;
    assign mem.prefetch = (cur.kind == VEC_B_COL);

    assign eng_in_valid_o = full_q;
    assign eng_in_data_o  = buf_q[out_q];
    assign beat           = eng_in_valid_o && eng_in_ready_i;

    always_ff @(posedge wb_clk_i) begin
        if (wb_rst_i) begin
            active_q <= 1'b0;
            full_q   <= 1'b0;
            vec_q    <= '0;
            word_q   <= '0;
            out_q    <= '0;
        end else if (start_i) begin
            active_q <= 1'b1;
            full_q   <= 1'b0;
            vec_q    <= '0;
            word_q   <= '0;
            out_q    <= '0;
        end else begin
            if (mem.done) begin
                word_q <= word_q + 1'b1;                  // wraps to 0 after the last
                if (word_q == WORD_W'(MAT_DIM - 1))
                    full_q <= 1'b1;
            end
            if (beat) begin
                out_q <= out_q + 1'b1;
                if (out_q == WORD_W'(MAT_DIM - 1)) begin
                    full_q <= 1'b0;                       // drained, next fetch may start
                    vec_q  <= vec_q + 1'b1;
                    if (vec_q == VEC_W'(VEC_COUNT - 1))
                        active_q <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (mem.rdata_valid)
            buf_q[word_q] <= mem.rdata;
    end

    a_in_stable: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
        eng_in_valid_o && !eng_in_ready_i |=> eng_in_valid_o && $stable(eng_in_data_o));

endmodule

`default_nettype wire

//--- result_writeback.sv
`timescale 1ns/1ps
`default_nettype none

module result_writeback #(
    parameter int ADDR_W = 23,
    parameter int DATA_W = 32
) (
    input  logic              wb_clk_i,
    input  logic              wb_rst_i,
    input  logic              start_i,
    input  logic [ADDR_W-1:0] base_a_i,
    mem_req_if.requester      mem,
    input  logic              eng_out_valid_i,
    input  logic [DATA_W-1:0] eng_out_data_i,
    output logic              eng_out_ready_o,
    input  logic              eng_done_i,
    output logic              run_done_o
);
    import dma_mm_pkg::*;

    localparam int CNT_W = $clog2(RESULT_COUNT + 1);

    logic              active_q;
    logic              full_q;       // one result held until its write ends
    logic              acc_q;        // write taken by the controller
    logic              eng_done_q;
    logic [CNT_W-1:0]  cnt_q;
    logic [DATA_W-1:0] res_q;
    logic              take;
    logic              wr_end;

    assign eng_out_ready_o = active_q && !full_q;
    assign take            = eng_out_valid_i && eng_out_ready_o;
    assign wr_end          = mem.done && acc_q;
    assign run_done_o      = active_q && eng_done_q && (cnt_q == CNT_W'(RESULT_COUNT));

    // results overwrite A in row-major order
    assign mem.req      = full_q;
    assign mem.rw       = 1'b1;
    assign mem.addr     = base_a_i + ADDR_W'(cnt_q * WORD_BYTES);
    assign mem.wdata    = res_q;
    assign mem.prefetch = 1'b0;

    always_ff @(posedge wb_clk_i) begin
        if (wb_rst_i) begin
            active_q   <= 1'b0;
            full_q     <= 1'b0;
            acc_q      <= 1'b0;
            eng_done_q <= 1'b0;
            cnt_q      <= '0;
        end else if (start_i) begin
            active_q   <= 1'b1;
            full_q     <= 1'b0;
            acc_q      <= 1'b0;
            eng_done_q <= 1'b0;
            cnt_q      <= '0;
        end else begin
            if (take)
                full_q <= 1'b1;
            if (mem.accept)
                acc_q <= 1'b1;
            if (wr_end) begin
                full_q <= 1'b0;
                acc_q  <= 1'b0;
                cnt_q  <= cnt_q + 1'b1;
            end
            if (active_q && eng_done_i)
                eng_done_q <= 1'b1;                   // engine done may be a pulse
            if (run_done_o)
                active_q <= 1'b0;
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (take)
            res_q <= eng_out_data_i;
    end

    // no write may complete once all results are counted
    a_cnt_max: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
        cnt_q == CNT_W'(RESULT_COUNT) |-> !wr_end);

endmodule

`default_nettype wire

//--- sdram_port_arb.sv
`timescale 1ns/1ps
`default_nettype none

module sdram_port_arb #(
    parameter int ADDR_W = 23,
    parameter int DATA_W = 32
) (
    input  logic              wb_clk_i,
    input  logic              wb_rst_i,
    mem_req_if.arbiter        fetch,
    mem_req_if.arbiter        wback,
    output logic [ADDR_W-1:0] sdram_addr_o,
    output logic              sdram_rw_o,
    output logic [DATA_W-1:0] sdram_wdata_o,
    output logic              sdram_in_valid_o,
    output logic              sdram_prefetch_o,
    input  logic              sdram_busy_i,
    input  logic              sdram_out_valid_i,
    input  logic [DATA_W-1:0] sdram_rdata_i
);
    logic gnt_f_q;
    logic gnt_w_q;
    logic acc_q;         // request accepted, waiting for the end
    logic idle;
    logic accepted;
    logic rd_end;
    logic wr_end;
    logic xfer_end;

    assign idle     = !gnt_f_q && !gnt_w_q;
    assign accepted = sdram_in_valid_o && sdram_busy_i;
    assign rd_end   = acc_q && !sdram_rw_o && sdram_out_valid_i;
    assign wr_end   = acc_q && sdram_rw_o && !sdram_busy_i;    // busy released after a write
    assign xfer_end = rd_end || wr_end;

    always_ff @(posedge wb_clk_i) begin
        if (wb_rst_i) begin
            gnt_f_q          <= 1'b0;
            gnt_w_q          <= 1'b0;
            acc_q            <= 1'b0;
            sdram_in_valid_o <= 1'b0;
        end else if (idle) begin
            if (wback.req) begin                  // writeback first
                gnt_w_q          <= 1'b1;
                sdram_in_valid_o <= 1'b1;
            end else if (fetch.req) begin
                gnt_f_q          <= 1'b1;
                sdram_in_valid_o <= 1'b1;
            end
        end else begin
            if (accepted) begin
                sdram_in_valid_o <= 1'b0;
                acc_q            <= 1'b1;
            end
            if (xfer_end) begin
                gnt_f_q <= 1'b0;
                gnt_w_q <= 1'b0;
                acc_q   <= 1'b0;
            end
        end
    end

    // request fields captured at grant, held until done
    always_ff @(posedge wb_clk_i) begin
        if (idle) begin
            sdram_addr_o     <= wback.req ? wback.addr : fetch.addr;
            sdram_rw_o       <= wback.req ? wback.rw : fetch.rw;
            sdram_wdata_o    <= wback.req ? wback.wdata : fetch.wdata;
            sdram_prefetch_o <= wback.req ? wback.prefetch : fetch.prefetch;
        end
    end

    assign fetch.accept      = gnt_f_q && accepted;
    assign fetch.rdata_valid = gnt_f_q && rd_end;
    assign fetch.rdata       = sdram_rdata_i;
    assign fetch.done        = gnt_f_q && xfer_end;

    assign wback.accept      = gnt_w_q && accepted;
    assign wback.rdata_valid = gnt_w_q && rd_end;
    assign wback.rdata       = sdram_rdata_i;
    assign wback.done        = gnt_w_q && xfer_end;

    a_one_grant: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
        !(gnt_f_q && gnt_w_q) && (sdram_in_valid_o -> (gnt_f_q || gnt_w_q)));

endmodule

`default_nettype wire

//--- sources.f
dma_mm_pkg.sv
mem_req_if.sv
dma_mm_regs.sv
operand_feeder.sv
result_writeback.sv
sdram_port_arb.sv
dma_mm_top.sv
tb_models.sv
tb_dma_mm.sv

//--- tb_dma_mm.sv
`timescale 1ns/1ps
`default_nettype none

module tb_dma_mm;
    localparam int ADDR_W         = 23;
    localparam int DATA_W         = 32;
    localparam int RUNS           = 3;
    localparam int RUN_CYCLES     = 2000;
    localparam int SETUP_CYCLES   = 200;     // register checks before the first run
    localparam int TIMEOUT_CYCLES = RUNS * RUN_CYCLES + SETUP_CYCLES;
    localparam logic [31:0] ADR_CTRL     = 32'h00;
    localparam logic [31:0] ADR_BASE_A   = 32'h04;
    localparam logic [31:0] ADR_BASE_B   = 32'h08;
    localparam logic [31:0] ADR_UNMAPPED = 32'h10;
    localparam int STAT_DONE = 1;
    localparam int STAT_IDLE = 2;

    logic              wb_clk_i;
    logic              wb_rst_i;
    logic              wbs_stb_i;
    logic              wbs_cyc_i;
    logic              wbs_we_i;
    logic [3:0]        wbs_sel_i;
    logic [31:0]       wbs_adr_i;
    logic [31:0]       wbs_dat_i;
    logic              wbs_ack_o;
    logic [31:0]       wbs_dat_o;
    logic [ADDR_W-1:0] sdram_addr_o;
    logic              sdram_rw_o;
    logic [DATA_W-1:0] sdram_wdata_o;
    logic              sdram_in_valid_o;
    logic              sdram_prefetch_o;
    logic              sdram_busy_i;
    logic              sdram_out_valid_i;
    logic [DATA_W-1:0] sdram_rdata_i;
    logic              eng_start_o;
    logic              eng_in_valid_o;
    logic [DATA_W-1:0] eng_in_data_o;
    logic              eng_in_ready_i;
    logic              eng_out_valid_i;
    logic [DATA_W-1:0] eng_out_data_i;
    logic              eng_out_ready_o;
    logic              eng_done_i;
    logic              load;
    logic [ADDR_W-1:0] load_addr;
    logic [DATA_W-1:0] load_data;

    integer            seed = 21424;
    logic [ADDR_W-1:0] run_base_a = '0;
    logic [ADDR_W-1:0] run_base_b = '0;
    logic [DATA_W-1:0] a_mat [16];
    logic [DATA_W-1:0] b_mat [16];
    logic [DATA_W-1:0] c_ref [16];
    int                rd_cnt = 0;
    int                wr_cnt = 0;
    int                cycle_cnt = 0;
    logic              any_req = 1'b0;

    dma_mm_top #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) dut (.*);

    sdram_model #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) sdram_m (
        .clk_i       (wb_clk_i),
        .rst_i       (wb_rst_i),
        .addr_i      (sdram_addr_o),
        .rw_i        (sdram_rw_o),
        .wdata_i     (sdram_wdata_o),
        .in_valid_i  (sdram_in_valid_o),
        .busy_o      (sdram_busy_i),
        .out_valid_o (sdram_out_valid_i),
        .rdata_o     (sdram_rdata_i),
        .load_i      (load),
        .load_addr_i (load_addr),
        .load_data_i (load_data)
    );

    matmul_engine_model #(.DATA_W(DATA_W)) engine_m (
        .clk_i       (wb_clk_i),
        .rst_i       (wb_rst_i),
        .start_i     (eng_start_o),
        .in_valid_i  (eng_in_valid_o),
        .in_data_i   (eng_in_data_o),
        .in_ready_o  (eng_in_ready_i),
        .out_valid_o (eng_out_valid_i),
        .out_data_o  (eng_out_data_i),
        .out_ready_i (eng_out_ready_o),
        .done_o      (eng_done_i)
    );

    initial begin
        wb_clk_i = 1'b0;
        forever #4 wb_clk_i = ~wb_clk_i;
    end

    task automatic abort_run();
        $display("FAIL: see errors above");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("[FAIL] %0t %s: got %h expected %h", $time, name, got, exp);
            abort_run();
        end
    endtask

    // operand n: A row 0, B columns 0..3, A rows 1..3, four words each
    function automatic logic [ADDR_W-1:0] read_addr(input int n, input logic [ADDR_W-1:0] ba,
                                                    input logic [ADDR_W-1:0] bb);
        int v;
        int k;
        v = n / 4;
        k = n % 4;
        if (v == 0)
            return ba + ADDR_W'(4 * k);
        else if (v <= 4)
            return bb + ADDR_W'(4 * (v - 1) + 16 * k);
        return ba + ADDR_W'(16 * (v - 4) + 4 * k);
    endfunction

    function automatic logic is_b_read(input int n);
        return (n / 4 >= 1) && (n / 4 <= 4);
    endfunction

    task automatic wb_access(input logic we, input logic [31:0] adr, input logic [31:0] wdat,
                             output logic [31:0] rdat);
        int waited;
        @(posedge wb_clk_i);
        wbs_stb_i <= 1'b1;
        wbs_cyc_i <= 1'b1;
        wbs_we_i  <= we;
        wbs_adr_i <= adr;
        wbs_dat_i <= wdat;
        waited = 0;
        do begin
            @(posedge wb_clk_i);
            waited++;
        end while (!wbs_ack_o && waited < 8);
        rdat = wbs_dat_o;
        wbs_stb_i <= 1'b0;
        wbs_cyc_i <= 1'b0;
        wbs_we_i  <= 1'b0;
        check_value("wbs_ack_o latency", 32'(waited), 32'd2);   // ack one cycle after stb
    endtask

    task automatic preload_word(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
        @(posedge wb_clk_i);
        load      <= 1'b1;
        load_addr <= addr;
        load_data <= data;
    endtask

    // random bases and matrices, reference product, SDRAM preload
    task automatic setup_run();
        logic [31:0] acc;
        run_base_a = ADDR_W'(({$random(seed)} % 32'h1000) * 64);
        run_base_b = run_base_a + ADDR_W'((1 + {$random(seed)} % 32'h100) * 64);
        for (int i = 0; i < 16; i++) begin
            a_mat[i] = $random(seed);
            b_mat[i] = $random(seed);
        end
        for (int r = 0; r < 4; r++) begin
            for (int c = 0; c < 4; c++) begin
                acc = '0;
                for (int k = 0; k < 4; k++)
                    acc += a_mat[4 * r + k] * b_mat[4 * k + c];
                c_ref[4 * r + c] = acc;
            end
        end
        for (int i = 0; i < 16; i++) begin
            preload_word(run_base_a + ADDR_W'(4 * i), a_mat[i]);
            preload_word(run_base_b + ADDR_W'(4 * i), b_mat[i]);
        end
        @(posedge wb_clk_i);
        load <= 1'b0;
    endtask

    // watches every request the controller accepts
    always @(posedge wb_clk_i) begin
        if (sdram_in_valid_o)
            any_req <= 1'b1;
        if (eng_start_o) begin
            rd_cnt <= 0;
            wr_cnt <= 0;
        end else if (sdram_in_valid_o && sdram_busy_i) begin
            if (!sdram_rw_o) begin
                assert (rd_cnt < 32) else begin
                    $display("more than 32 operand reads in one run");
                    abort_run();
                end
                check_value("sdram_addr_o", 32'(sdram_addr_o),
                            32'(read_addr(rd_cnt, run_base_a, run_base_b)));
                check_value("sdram_prefetch_o", 32'(sdram_prefetch_o), 32'(is_b_read(rd_cnt)));
                rd_cnt <= rd_cnt + 1;
            end else begin
                assert (wr_cnt < 16) else begin
                    $display("more than 16 result writes in one run");
                    abort_run();
                end
                check_value("sdram_addr_o", 32'(sdram_addr_o),
                            32'(run_base_a + ADDR_W'(4 * wr_cnt)));
                check_value("sdram_wdata_o", sdram_wdata_o, c_ref[wr_cnt]);
                wr_cnt <= wr_cnt + 1;
            end
        end
    end

    always @(posedge wb_clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            abort_run();
        end
    end

    initial begin
        logic [31:0] rd;
        wb_rst_i  = 1'b1;
        wbs_stb_i = 1'b0;
        wbs_cyc_i = 1'b0;
        wbs_we_i  = 1'b0;
        wbs_sel_i = 4'hf;
        wbs_adr_i = '0;
        wbs_dat_i = '0;
        load      = 1'b0;
        load_addr = '0;
        load_data = '0;
        repeat (2) @(posedge wb_clk_i);
        wb_rst_i <= 1'b0;

        // outputs quiet straight out of reset
        check_value("wbs_ack_o", 32'(wbs_ack_o), 32'd0);
        check_value("sdram_in_valid_o", 32'(sdram_in_valid_o), 32'd0);
        check_value("eng_start_o", 32'(eng_start_o), 32'd0);
        check_value("eng_in_valid_o", 32'(eng_in_valid_o), 32'd0);
        check_value("eng_out_ready_o", 32'(eng_out_ready_o), 32'd0);

        wb_access(1'b0, ADR_CTRL, '0, rd);
        check_value("status idle", 32'(rd[STAT_IDLE]), 32'd1);
        check_value("status done", 32'(rd[STAT_DONE]), 32'd0);
        wb_access(1'b0, ADR_UNMAPPED, '0, rd);
        check_value("unmapped read", rd, 32'd0);

        // start with only base A written must be ignored
        wb_access(1'b1, ADR_BASE_A, 32'h100, rd);
        wb_access(1'b1, ADR_CTRL, 32'h1, rd);
        repeat (20) @(posedge wb_clk_i);
        wb_access(1'b0, ADR_CTRL, '0, rd);
        check_value("status idle", 32'(rd[STAT_IDLE]), 32'd1);
        assert (!any_req) else begin
            $display("SDRAM request issued after a start without both bases");
            abort_run();
        end

        for (int run = 0; run < RUNS; run++) begin
            setup_run();
            wb_access(1'b1, ADR_BASE_A, 32'(run_base_a), rd);
            wb_access(1'b1, ADR_BASE_B, 32'(run_base_b), rd);
            wb_access(1'b0, ADR_BASE_A, '0, rd);
            check_value("base A", rd, 32'(run_base_a));
            wb_access(1'b0, ADR_BASE_B, '0, rd);
            check_value("base B", rd, 32'(run_base_b));
            wb_access(1'b1, ADR_CTRL, 32'h1, rd);
            wb_access(1'b0, ADR_CTRL, '0, rd);
            check_value("status idle", 32'(rd[STAT_IDLE]), 32'd0);
            while (!rd[STAT_IDLE]) begin
                check_value("status done", 32'(rd[STAT_DONE]), 32'd0);
                repeat (8) @(posedge wb_clk_i);
                wb_access(1'b0, ADR_CTRL, '0, rd);
            end
            check_value("status done", 32'(rd[STAT_DONE]), 32'd1);
            check_value("read count", 32'(rd_cnt), 32'd32);
            check_value("write count", 32'(wr_cnt), 32'd16);
        end

        $display("PASS: all tests");
        $finish;
    end

endmodule

`default_nettype wire

//--- tb_models.sv
`timescale 1ns/1ps
`default_nettype none

// single-port SDRAM controller with random busy time per request
module sdram_model #(
    parameter int ADDR_W = 23,
    parameter int DATA_W = 32
) (
    input  logic              clk_i,
    input  logic              rst_i,
    input  logic [ADDR_W-1:0] addr_i,
    input  logic              rw_i,
    input  logic [DATA_W-1:0] wdata_i,
    input  logic              in_valid_i,
    output logic              busy_o,
    output logic              out_valid_o,
    output logic [DATA_W-1:0] rdata_o,
    input  logic              load_i,        // backdoor preload, one word per cycle
    input  logic [ADDR_W-1:0] load_addr_i,
    input  logic [DATA_W-1:0] load_data_i
);
    logic [DATA_W-1:0] mem [logic [ADDR_W-1:0]];
    integer            seed = 21424;
    logic              busy_q = 1'b0;
    logic              out_valid_q = 1'b0;
    logic [DATA_W-1:0] rdata_q = '0;
    logic              pending = 1'b0;
    int                delay = 0;
    logic [ADDR_W-1:0] addr_q = '0;
    logic              rw_q = 1'b0;
    logic [DATA_W-1:0] wdata_q = '0;

    assign busy_o      = busy_q;
    assign out_valid_o = out_valid_q;
    assign rdata_o     = rdata_q;

    always @(posedge clk_i) begin
        if (rst_i) begin
            busy_q      <= 1'b0;
            out_valid_q <= 1'b0;
            pending     <= 1'b0;
        end else begin
            out_valid_q <= 1'b0;
            if (load_i)
                mem[load_addr_i] = load_data_i;
            if (!pending) begin
                if (in_valid_i) begin
                    busy_q  <= 1'b1;          // request taken on the next edge
                    pending <= 1'b1;
                    addr_q  <= addr_i;
                    rw_q    <= rw_i;
                    wdata_q <= wdata_i;
                    delay   <= {$random(seed)} % 5;
                end
            end else if (delay > 0) begin
                delay <= delay - 1;
            end else begin
                busy_q  <= 1'b0;
                pending <= 1'b0;
                if (rw_q) begin
                    mem[addr_q] = wdata_q;
                end else begin
                    out_valid_q <= 1'b1;
                    rdata_q     <= mem.exists(addr_q) ? mem[addr_q] : '0;
                end
            end
        end
    end
endmodule

// 4x4 matmul engine, consumes A row 0, B columns 0..3, then A rows 1..3
module matmul_engine_model #(
    parameter int DATA_W = 32
) (
    input  logic              clk_i,
    input  logic              rst_i,
    input  logic              start_i,
    input  logic              in_valid_i,
    input  logic [DATA_W-1:0] in_data_i,
    output logic              in_ready_o,
    output logic              out_valid_o,
    output logic [DATA_W-1:0] out_data_o,
    input  logic              out_ready_i,
    output logic              done_o
);
    logic [DATA_W-1:0] a_row [4][4];
    logic [DATA_W-1:0] b_col [4][4];
    logic [DATA_W-1:0] res_q [$];
    integer            seed = 21424;
    int                vec = 0;
    int                word = 0;
    int                emitted = 0;
    logic              in_ready_q = 1'b0;
    logic              out_valid_q = 1'b0;
    logic [DATA_W-1:0] out_data_q = '0;
    logic              done_q = 1'b0;

    assign in_ready_o  = in_ready_q;
    assign out_valid_o = out_valid_q;
    assign out_data_o  = out_data_q;
    assign done_o      = done_q;

    function automatic logic [DATA_W-1:0] dot(input int r, input int c);
        logic [DATA_W-1:0] acc;
        acc = '0;
        for (int k = 0; k < 4; k++)
            acc += a_row[r][k] * b_col[c][k];
        return acc;
    endfunction

    always @(posedge clk_i) begin
        int r;
        if (rst_i || start_i) begin
            in_ready_q  <= 1'b0;
            out_valid_q <= 1'b0;
            done_q      <= 1'b0;
            vec = 0;
            word = 0;
            emitted = 0;
            res_q.delete();
        end else begin
            in_ready_q <= ({$random(seed)} % 4) != 0;     // stalls about one cycle in four
            if (in_valid_i && in_ready_q) begin
                if (vec == 0 || vec >= 5)
                    a_row[(vec == 0) ? 0 : vec - 4][word] = in_data_i;
                else
                    b_col[vec - 1][word] = in_data_i;
                word = word + 1;
                if (word == 4) begin
                    word = 0;
                    if (vec >= 4) begin
                        r = (vec == 4) ? 0 : vec - 4;    // row 0 waits for all of B
                        for (int c = 0; c < 4; c++)
                            res_q.push_back(dot(r, c));
                    end
                    vec = vec + 1;
                end
            end
            if (out_valid_q && out_ready_i) begin
                out_valid_q <= 1'b0;
                emitted = emitted + 1;
                if (emitted == 16)
                    done_q <= 1'b1;                       // held until the next start
            end else if (!out_valid_q && res_q.size() > 0 && ($random(seed) & 1) != 0) begin
                out_data_q  <= res_q.pop_front();
                out_valid_q <= 1'b1;
            end
        end
    end
endmodule

`default_nettype wire
